/* source/mister_pkg.sv */
// MiSTer frame shared definitions: download index codes, download states and field widths
package mister_pkg;

    // Index codes sent by the HPS with each download
    typedef enum logic [7:0] {
        DL_ROM      = 8'd0,
        DL_CORE_MOD = 8'd1,
        DL_DIPSW    = 8'd254
    } dl_index_e;

    // ROM download handshake states
    typedef enum logic [1:0] {
        IDLE     = 2'd0,
        LOAD     = 2'd1,
        WAIT_RDY = 2'd2,
        FINISH   = 2'd3
    } dl_state_e;

    // Sync offset field width, also sets the depth of the resync delay lines
    localparam int OFFSETW = 4;

    // DIP switch word, four bytes loaded one at a time
    localparam int DIPW = 32;

    // Core mode register
    localparam int COREMODW = 7;

endpackage

/* source/mister_dwnld.sv */
// MiSTer download router: ROM write handshake with the programming port and configuration registers
`timescale 1ns/1ps

module mister_dwnld #(
    parameter int ADDRW = 27
) (
    input  logic                              clk_sys,
    input  logic                              rst_n,

    // HPS download stream
    input  logic                              hps_download,
    input  mister_pkg::dl_index_e             hps_index,
    input  logic                              hps_wr,
    input  logic [ADDRW-1:0]                  hps_addr,
    input  logic [7:0]                        hps_dout,
    output logic                              hps_wait,

    // Game programming side
    input  logic                              prog_rdy,
    input  logic                              dwnld_busy,
    output logic                              ioctl_rom_wr,
    output logic [ADDRW-1:0]                  ioctl_addr,
    output logic [7:0]                        ioctl_dout,
    output logic                              downloading,

    // Configuration
    output logic [mister_pkg::DIPW-1:0]       dipsw,
    output logic [mister_pkg::COREMODW-1:0]   core_mod
);

    import mister_pkg::*;

    dl_state_e state;
    dl_state_e state_nxt;

    logic rom_start;
    logic rom_wr;
    logic dipsw_wr;
    logic coremod_wr;

    // Index decode
    assign rom_start  = hps_download && (hps_index == DL_ROM);
    // A write while the wait is up breaks the protocol, so it is dropped
    assign rom_wr     = rom_start && hps_wr && !hps_wait;
    assign dipsw_wr   = hps_wr && (hps_index == DL_DIPSW);
    assign coremod_wr = hps_wr && (hps_index == DL_CORE_MOD) && (hps_addr == '0);

    // The HPS is held back while a byte waits for the programming side
    assign hps_wait    = (state == WAIT_RDY);
    assign downloading = (state != IDLE);

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE: begin
                if (rom_wr) begin
                    state_nxt = WAIT_RDY;
                end else if (rom_start) begin
                    state_nxt = LOAD;
                end
            end
            LOAD: begin
                if (rom_wr) begin
                    state_nxt = WAIT_RDY;
                end else if (!hps_download) begin
                    // Game may still be busy post-processing the ROM
                    state_nxt = dwnld_busy ? FINISH : IDLE;
                end
            end
            WAIT_RDY: begin
                if (prog_rdy) begin
                    state_nxt = LOAD;
                end
            end
            FINISH: begin
                if (rom_wr) begin
                    state_nxt = WAIT_RDY;
                end else if (rom_start) begin
                    state_nxt = LOAD;
                end else if (!dwnld_busy) begin
                    state_nxt = IDLE;
                end
            end
            default: begin
                state_nxt = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk_sys or negedge rst_n) begin
        if (!rst_n) begin
            state        <= IDLE;
            ioctl_rom_wr <= 1'b0;
        end else begin
            state        <= state_nxt;
            ioctl_rom_wr <= rom_wr;
        end
    end

    // Address and byte held for the programming side
    always_ff @(posedge clk_sys) begin
        if (rom_wr) begin
            ioctl_addr <= hps_addr;
            ioctl_dout <= hps_dout;
        end
    end

    // Byte lane picked by the two low address bits
    always_ff @(posedge clk_sys or negedge rst_n) begin
        if (!rst_n) begin
            dipsw <= '0;
        end else if (dipsw_wr) begin
            dipsw[{hps_addr[1:0], 3'b000} +: 8] <= hps_dout;
        end
    end

    // Only the first byte of a core mode download matters
    always_ff @(posedge clk_sys or negedge rst_n) begin
        if (!rst_n) begin
            core_mod <= '0;
        end else if (coremod_wr) begin
            core_mod <= hps_dout[COREMODW-1:0];
        end
    end

endmodule

/* source/mister_resync.sv */
// MiSTer sync re-timer: delays hs by pixel ticks and vs by line starts
`timescale 1ns/1ps

module mister_resync (
    input  logic                          clk_sys,
    input  logic                          rst_n,
    input  logic                          pxl_cen,
    input  logic                          hs,
    input  logic                          vs,
    input  logic [mister_pkg::OFFSETW-1:0] hoffset,
    input  logic [mister_pkg::OFFSETW-1:0] voffset,
    output logic                          hs_out,
    output logic                          vs_out
);

    import mister_pkg::*;

    localparam int DEPTH = 2 ** OFFSETW;

    // Bit 0 holds the most recent sample
    logic [DEPTH-1:0] hs_sr;
    logic [DEPTH-1:0] vs_sr;
    logic             line_start;

    // hs_sr[0] is hs as seen on the previous tick
    assign line_start = pxl_cen && hs && !hs_sr[0];

    // One sample per pixel tick
    always_ff @(posedge clk_sys or negedge rst_n) begin
        if (!rst_n) begin
            hs_sr <= '0;
        end else if (pxl_cen) begin
            hs_sr <= {hs_sr[DEPTH-2:0], hs};
        end
    end

    // One sample per line
    always_ff @(posedge clk_sys or negedge rst_n) begin
        if (!rst_n) begin
            vs_sr <= '0;
        end else if (line_start) begin
            vs_sr <= {vs_sr[DEPTH-2:0], vs};
        end
    end

    // Offset selects how far back the tap looks
    assign hs_out = hs_sr[hoffset];
    assign vs_out = vs_sr[voffset];

endmodule

/* source/mister_frame.sv */
// MiSTer frame shell top level: download router and sync re-timer
`timescale 1ns/1ps

module mister_frame #(
    parameter int ADDRW = 27
) (
    input  logic                              clk_sys,
    input  logic                              rst_n,

    // HPS side
    input  logic                              hps_download,
    input  mister_pkg::dl_index_e             hps_index,
    input  logic                              hps_wr,
    input  logic [ADDRW-1:0]                  hps_addr,
    input  logic [7:0]                        hps_dout,
    input  logic [31:0]                       status,
    output logic                              hps_wait,

    // ROM programming
    input  logic                              prog_rdy,
    input  logic                              dwnld_busy,
    output logic                              ioctl_rom_wr,
    output logic [ADDRW-1:0]                  ioctl_addr,
    output logic [7:0]                        ioctl_dout,
    output logic                              downloading,

    // Configuration words
    output logic [mister_pkg::DIPW-1:0]       dipsw,
    output logic [mister_pkg::COREMODW-1:0]   core_mod,

    // Video sync
    input  logic                              pxl_cen,
    input  logic                              hs,
    input  logic                              vs,
    output logic                              hs_out,
    output logic                              vs_out
);

    import mister_pkg::*;

    logic [OFFSETW-1:0] hoffset;
    logic [OFFSETW-1:0] voffset;

    // Sync offsets live in the top status byte
    assign {voffset, hoffset} = status[31:24];

    mister_dwnld #(
        .ADDRW        ( ADDRW        )
    ) u_dwnld (
        .clk_sys      ( clk_sys      ),
        .rst_n        ( rst_n        ),
        .hps_download ( hps_download ),
        .hps_index    ( hps_index    ),
        .hps_wr       ( hps_wr       ),
        .hps_addr     ( hps_addr     ),
        .hps_dout     ( hps_dout     ),
        .hps_wait     ( hps_wait     ),
        .prog_rdy     ( prog_rdy     ),
        .dwnld_busy   ( dwnld_busy   ),
        .ioctl_rom_wr ( ioctl_rom_wr ),
        .ioctl_addr   ( ioctl_addr   ),
        .ioctl_dout   ( ioctl_dout   ),
        .downloading  ( downloading  ),
        .dipsw        ( dipsw        ),
        .core_mod     ( core_mod     )
    );

    mister_resync u_resync (
        .clk_sys      ( clk_sys      ),
        .rst_n        ( rst_n        ),
        .pxl_cen      ( pxl_cen      ),
        .hs           ( hs           ),
        .vs           ( vs           ),
        .hoffset      ( hoffset      ),
        .voffset      ( voffset      ),
        .hs_out       ( hs_out       ),
        .vs_out       ( vs_out       )
    );

endmodule

/* dv/mister_frame_asserts.sv */
// Download handshake assertions, bound into the download router
`timescale 1ns/1ps

module mister_frame_asserts (
    input logic clk_sys,
    input logic rst_n,
    input logic hps_wr,
    input logic hps_wait,
    input logic ioctl_rom_wr
);

    int rom_wr_len_errs = 0;
    int wr_in_wait_errs = 0;
    int wait_missing_errs = 0;
    int fail_total;

    assign fail_total = rom_wr_len_errs + wr_in_wait_errs + wait_missing_errs;

    // One strobe per ROM byte
    a_rom_wr_single: assert property (@(posedge clk_sys) disable iff (!rst_n)
        ioctl_rom_wr |=> !ioctl_rom_wr)
    else begin
        rom_wr_len_errs++;
        $error("ioctl_rom_wr stayed high for more than one cycle");
    end

    a_no_wr_in_wait: assert property (@(posedge clk_sys) disable iff (!rst_n)
        !(hps_wr && hps_wait))
    else begin
        wr_in_wait_errs++;
        $error("hps_wr arrived while hps_wait was high");
    end

    // Wait goes up together with the strobe
    a_wait_with_rom_wr: assert property (@(posedge clk_sys) disable iff (!rst_n)
        ioctl_rom_wr |-> hps_wait)
    else begin
        wait_missing_errs++;
        $error("ioctl_rom_wr high without hps_wait");
    end

endmodule

bind mister_dwnld mister_frame_asserts u_asserts (
    .clk_sys      ( clk_sys      ),
    .rst_n        ( rst_n        ),
    .hps_wr       ( hps_wr       ),
    .hps_wait     ( hps_wait     ),
    .ioctl_rom_wr ( ioctl_rom_wr )
);

/* dv/tb_mister_frame.sv */
// Directed testbench for the MiSTer frame shell covering ROM download, configuration and sync re-timing
`timescale 1ns/1ps

module tb_mister_frame;

    import mister_pkg::*;

    localparam int ADDRW = 27;
    localparam logic [31:0] SEED = 32'h9f851ba6;
    // Several times the length of all tests together
    localparam int TIMEOUT_CYCLES = 20000;

    logic                clk_sys;
    logic                rst_n;
    logic                hps_download;
    dl_index_e           hps_index;
    logic                hps_wr;
    logic [ADDRW-1:0]    hps_addr;
    logic [7:0]          hps_dout;
    logic [31:0]         status;
    logic                hps_wait;
    logic                prog_rdy;
    logic                dwnld_busy;
    logic                ioctl_rom_wr;
    logic [ADDRW-1:0]    ioctl_addr;
    logic [7:0]          ioctl_dout;
    logic                downloading;
    logic [DIPW-1:0]     dipsw;
    logic [COREMODW-1:0] core_mod;
    logic                pxl_cen;
    logic                hs;
    logic                vs;
    logic                hs_out;
    logic                vs_out;

    logic [31:0] data_rng = SEED;
    logic [31:0] rdy_rng = ~SEED;
    int          rdy_delay;
    int          cycle_count;

    mister_frame #(
        .ADDRW ( ADDRW )
    ) u_mister_frame (
        .clk_sys ( clk_sys ), .rst_n ( rst_n ),
        .hps_download ( hps_download ), .hps_index ( hps_index ), .hps_wr ( hps_wr ),
        .hps_addr ( hps_addr ), .hps_dout ( hps_dout ), .status ( status ),
        .hps_wait ( hps_wait ), .prog_rdy ( prog_rdy ), .dwnld_busy ( dwnld_busy ),
        .ioctl_rom_wr ( ioctl_rom_wr ), .ioctl_addr ( ioctl_addr ),
        .ioctl_dout ( ioctl_dout ), .downloading ( downloading ),
        .dipsw ( dipsw ), .core_mod ( core_mod ),
        .pxl_cen ( pxl_cen ), .hs ( hs ), .vs ( vs ),
        .hs_out ( hs_out ), .vs_out ( vs_out )
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic report_failure();
        $display("*** TEST FAILED ***");
        $fatal(1, "stopping at the first mismatch");
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("CHECK FAILED: %s got 0x%h expected 0x%h", name, got, exp);
            report_failure();
        end
    endtask

    task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
        if (got !== exp) begin
            $display("CHECK FAILED: %s got 0x%h expected 0x%h", name, got, exp);
            report_failure();
        end
    endtask

    task automatic check_addr(input string name, input logic [ADDRW-1:0] got,
                              input logic [ADDRW-1:0] exp);
        if (got !== exp) begin
            $display("CHECK FAILED: %s got 0x%h expected 0x%h", name, got, exp);
            report_failure();
        end
    endtask

    task automatic check_dipsw(input string name, input logic [DIPW-1:0] got,
                               input logic [DIPW-1:0] exp);
        if (got !== exp) begin
            $display("CHECK FAILED: %s got 0x%h expected 0x%h", name, got, exp);
            report_failure();
        end
    endtask

    task automatic check_core_mod(input string name, input logic [COREMODW-1:0] got,
                                  input logic [COREMODW-1:0] exp);
        if (got !== exp) begin
            $display("CHECK FAILED: %s got 0x%h expected 0x%h", name, got, exp);
            report_failure();
        end
    endtask

    // Inputs change just after the rising edge
    task automatic next_cycle();
        @(posedge clk_sys);
        #1;
    endtask

    task automatic wait_hps_ready();
        while (hps_wait) begin
            next_cycle();
        end
    endtask

    task automatic rom_write(input logic [ADDRW-1:0] addr, input logic [7:0] data);
        wait_hps_ready();
        hps_index = DL_ROM;
        hps_addr  = addr;
        hps_dout  = data;
        hps_wr    = 1'b1;
        next_cycle();
        hps_wr = 1'b0;
        check_bit("ioctl_rom_wr", ioctl_rom_wr, 1'b1);
        check_bit("hps_wait", hps_wait, 1'b1);
        check_addr("ioctl_addr", ioctl_addr, addr);
        check_byte("ioctl_dout", ioctl_dout, data);
    endtask

    task automatic cfg_write(input dl_index_e index, input logic [ADDRW-1:0] addr,
                             input logic [7:0] data);
        wait_hps_ready();
        hps_index = index;
        hps_addr  = addr;
        hps_dout  = data;
        hps_wr    = 1'b1;
        next_cycle();
        hps_wr = 1'b0;
    endtask

    // One pixel tick spread over two clocks
    task automatic pixel_tick(input logic hs_val, input logic vs_val);
        pxl_cen = 1'b1;
        hs      = hs_val;
        vs      = vs_val;
        next_cycle();
        pxl_cen = 1'b0;
        next_cycle();
    endtask

    // Line start on the first tick, then hs back low
    task automatic video_line(input logic vs_val);
        pixel_tick(1'b1, vs_val);
        pixel_tick(1'b0, vs_val);
    endtask

    task automatic measure_hs_delay(input logic level, output int ticks);
        ticks = 0;
        pixel_tick(level, 1'b0);
        while (hs_out !== level && ticks < 20) begin
            ticks++;
            pixel_tick(level, 1'b0);
        end
    endtask

    task automatic measure_vs_delay(input logic level, output int lines);
        lines = 0;
        video_line(level);
        while (vs_out !== level && lines < 20) begin
            lines++;
            video_line(level);
        end
    endtask

    task automatic test_reset_values();
        check_bit("ioctl_rom_wr", ioctl_rom_wr, 1'b0);
        check_bit("hps_wait", hps_wait, 1'b0);
        check_bit("downloading", downloading, 1'b0);
        check_bit("hs_out", hs_out, 1'b0);
        check_bit("vs_out", vs_out, 1'b0);
        check_dipsw("dipsw", dipsw, '0);
        check_core_mod("core_mod", core_mod, '0);
    endtask

    task automatic test_rom_download();
        logic [ADDRW-1:0] addr;
        addr = ADDRW'(32'h4000);
        hps_index    = DL_ROM;
        hps_download = 1'b1;
        next_cycle();
        check_bit("downloading", downloading, 1'b1);
        for (int i = 0; i < 64; i++) begin
            data_rng = xorshift32(data_rng);
            rom_write(addr, data_rng[7:0]);
            addr = addr + ADDRW'(1);
        end
    endtask

    // Game keeps the download open while it post-processes the ROM
    task automatic test_downloading_hold();
        wait_hps_ready();
        hps_download = 1'b0;
        dwnld_busy   = 1'b1;
        repeat (10) begin
            next_cycle();
            check_bit("downloading", downloading, 1'b1);
        end
        dwnld_busy = 1'b0;
        next_cycle();
        check_bit("downloading", downloading, 1'b0);
    endtask

    task automatic test_config_regs();
        logic [DIPW-1:0] exp_dip;
        logic [7:0]      data;
        exp_dip = '0;
        for (int k = 0; k < 4; k++) begin
            data_rng = xorshift32(data_rng);
            data = data_rng[7:0];
            cfg_write(DL_DIPSW, ADDRW'(32'h10 + k), data);
            exp_dip[k*8 +: 8] = data;
            check_dipsw("dipsw", dipsw, exp_dip);
        end
        data = 8'ha5;
        cfg_write(DL_CORE_MOD, '0, data);
        check_core_mod("core_mod", core_mod, data[COREMODW-1:0]);
        hps_download = 1'b1;
        rom_write(ADDRW'(3), 8'h3c);
        check_dipsw("dipsw", dipsw, exp_dip);
        wait_hps_ready();
        hps_download = 1'b0;
        next_cycle();
        check_bit("downloading", downloading, 1'b0);
        // Index 7 is not decoded, even at address 0 with the download flag up
        hps_download = 1'b1;
        cfg_write(dl_index_e'(8'h07), '0, 8'hff);
        hps_download = 1'b0;
        check_dipsw("dipsw", dipsw, exp_dip);
        check_core_mod("core_mod", core_mod, data[COREMODW-1:0]);
        check_bit("ioctl_rom_wr", ioctl_rom_wr, 1'b0);
        check_bit("hps_wait", hps_wait, 1'b0);
        check_bit("downloading", downloading, 1'b0);
    endtask

    task automatic test_hoffset(input logic [OFFSETW-1:0] off);
        int ticks;
        status = {4'h0, off, 24'h0};
        repeat (16) pixel_tick(1'b0, 1'b0);
        measure_hs_delay(1'b1, ticks);
        check_byte("hs_out rise delay", ticks[7:0], {4'h0, off});
        repeat (16) pixel_tick(1'b1, 1'b0);
        measure_hs_delay(1'b0, ticks);
        check_byte("hs_out fall delay", ticks[7:0], {4'h0, off});
    endtask

    task automatic test_voffset(input logic [OFFSETW-1:0] off);
        int lines;
        status = {off, 28'h0};
        repeat (16) video_line(1'b0);
        measure_vs_delay(1'b1, lines);
        check_byte("vs_out rise delay", lines[7:0], {4'h0, off});
        repeat (16) video_line(1'b1);
        measure_vs_delay(1'b0, lines);
        check_byte("vs_out fall delay", lines[7:0], {4'h0, off});
    endtask

    initial begin
        clk_sys = 1'b0;
        forever #50 clk_sys = ~clk_sys;
    end

    // Programming port answers each ROM write after 1 to 5 cycles
    initial begin
        forever begin
            next_cycle();
            if (ioctl_rom_wr) begin
                rdy_rng = xorshift32(rdy_rng);
                rdy_delay = int'(rdy_rng % 32'd5) + 1;
                repeat (rdy_delay) begin
                    check_bit("hps_wait", hps_wait, 1'b1);
                    next_cycle();
                end
                check_bit("hps_wait", hps_wait, 1'b1);
                prog_rdy = 1'b1;
                next_cycle();
                prog_rdy = 1'b0;
                check_bit("hps_wait", hps_wait, 1'b0);
            end
        end
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk_sys);
            cycle_count++;
        end
        $display("Timeout: the tests did not finish within %0d clock cycles", TIMEOUT_CYCLES);
        $display("*** TEST FAILED ***");
        $fatal(1, "simulation timeout");
    end

    initial begin
        rst_n        = 1'b0;
        hps_download = 1'b0;
        hps_index    = DL_ROM;
        hps_wr       = 1'b0;
        hps_addr     = '0;
        hps_dout     = '0;
        status       = '0;
        prog_rdy     = 1'b0;
        dwnld_busy   = 1'b0;
        pxl_cen      = 1'b0;
        hs           = 1'b0;
        vs           = 1'b0;
        repeat (4) @(posedge clk_sys);
        #1;
        rst_n = 1'b1;
        test_reset_values();
        test_rom_download();
        test_downloading_hold();
        test_config_regs();
        test_hoffset(4'd0);
        test_hoffset(4'd3);
        test_hoffset(4'd15);
        test_voffset(4'd0);
        test_voffset(4'd5);
        if (u_mister_frame.u_dwnld.u_asserts.fail_total == 0) begin
            $display("*** TEST PASSED ***");
            $finish;
        end else begin
            $display("*** TEST FAILED ***");
            $fatal(1, "bound assertions reported errors");
        end
    end

endmodule

/* list.f */
source/mister_pkg.sv
source/mister_dwnld.sv
source/mister_resync.sv
source/mister_frame.sv
dv/mister_frame_asserts.sv
dv/tb_mister_frame.sv

/* Makefile */
TOP := tb_mister_frame

.PHONY: all run clean

all: run

obj_dir/V$(TOP): list.f $(wildcard source/*.sv) $(wildcard dv/*.sv)
	verilator --binary --timing --assert --top-module $(TOP) -f list.f

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) > sim.log 2>&1; true
	@cat sim.log
	@if grep -qF '*** TEST FAILED ***' sim.log; then echo "Simulation failed"; exit 1; fi
	@if ! grep -qF '*** TEST PASSED ***' sim.log; then echo "Simulation gave no result"; exit 1; fi
	@echo "Simulation passed"

clean:
	rm -rf obj_dir sim.log
